// File: Makefile
TOP := tb_beeb_joy_front

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// File: design/beeb_joy_front.sv
module beeb_joy_front
	import mouse_pkt_pkg::*;
	import joy_port_pkg::*;
#(
	parameter int MOUSE_STEP_LIMIT = MOUSE_STEP_LIMIT_DEF
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	// host side
	input  mouse_pkt_t mouse_pkt,
	input  pad_word_t  pad1_buttons,
	input  pad_word_t  pad2_buttons,
	input  axis_t      pad1_x,
	input  axis_t      pad1_y,
	input  axis_t      pad2_x,
	input  axis_t      pad2_y,
	// menu controls
	input  logic       mouse_disable,
	input  logic       swap_ports,
	input  logic       soft_reset,
	// emulated analog ports
	output adc_word_t  port1_x,
	output adc_word_t  port1_y,
	output adc_word_t  port2_x,
	output adc_word_t  port2_y,
	output logic       port1_fire_n,
	output logic       port2_fire_n
);

	// ========================================
	// tracker to mapper
	// ========================================

	logic  mouse_mode;
	axis_t mouse_x;
	axis_t mouse_y;
	logic  mouse_fire;

	// packet to position, one cycle
	mouse_axis_tracker #(
		.STEP_LIMIT (MOUSE_STEP_LIMIT)
	) u_tracker (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.mouse_pkt     (mouse_pkt),
		.pad1_buttons  (pad1_buttons),
		.mouse_disable (mouse_disable),
		.soft_reset    (soft_reset),
		.mouse_mode    (mouse_mode),
		.mouse_x       (mouse_x),
		.mouse_y       (mouse_y),
		.mouse_fire    (mouse_fire)
	);

	// select, swap and convert, one more cycle
	joystick_port_mapper u_mapper (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.mouse_mode   (mouse_mode),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_fire   (mouse_fire),
		.pad1_buttons (pad1_buttons),
		.pad2_buttons (pad2_buttons),
		.pad1_x       (pad1_x),
		.pad1_y       (pad1_y),
		.pad2_x       (pad2_x),
		.pad2_y       (pad2_y),
		.swap_ports   (swap_ports),
		.port1_x      (port1_x),
		.port1_y      (port1_y),
		.port2_x      (port2_x),
		.port2_y      (port2_y),
		.port1_fire_n (port1_fire_n),
		.port2_fire_n (port2_fire_n)
	);

endmodule

// File: design/joy_port_pkg.sv
package joy_port_pkg;

	// ========================================
	// gamepad side
	// ========================================

	// 16-bit button word from the host, one bit per button
	typedef logic [15:0] pad_word_t;

	// first fire button
	localparam int PAD_FIRE_BIT = 4;

	// signed analog axis
	// -128 full left / up, 127 full right / down
	typedef logic signed [7:0] axis_t;

	// saturation bounds for accumulated positions
	localparam axis_t AXIS_MIN = axis_t'(-128);
	localparam axis_t AXIS_MAX = axis_t'(127);

	// ========================================
	// emulated analog port
	// ========================================

	// 12-bit word seen by the emulated ADC
	// upper byte is 127 - v modulo 256, so inverted offset binary
	// low nibble repeats the top nibble of that byte
	typedef logic [11:0] adc_word_t;

	// conversion of a centred axis
	// 127 - 0 = 0x7f, then 0x7 appended
	localparam adc_word_t ADC_CENTER = 12'h7f7;

endpackage

// File: design/joystick_port_mapper.sv
module joystick_port_mapper
	import joy_port_pkg::*;
(
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      mouse_mode,
	input  axis_t     mouse_x,
	input  axis_t     mouse_y,
	input  logic      mouse_fire,
	input  pad_word_t pad1_buttons,
	input  pad_word_t pad2_buttons,
	input  axis_t     pad1_x,
	input  axis_t     pad1_y,
	input  axis_t     pad2_x,
	input  axis_t     pad2_y,
	input  logic      swap_ports,
	output adc_word_t port1_x,
	output adc_word_t port1_y,
	output adc_word_t port2_x,
	output adc_word_t port2_y,
	output logic      port1_fire_n,
	output logic      port2_fire_n
);

	// source a, mouse or gamepad 1
	axis_t a_x;
	axis_t a_y;
	logic  a_fire;
	// source b, always gamepad 2
	logic  b_fire;

	// after the swap
	axis_t sel1_x;
	axis_t sel1_y;
	axis_t sel2_x;
	axis_t sel2_y;
	logic  sel1_fire;
	logic  sel2_fire;

	// inverted offset binary
	// 127 - v wraps -128 to 0xff and 127 to 0x00
	function automatic adc_word_t to_adc(axis_t v);
		logic [7:0] b;
		b = 8'd127 - 8'(v);
		return {b, b[7:4]};
	endfunction

	// ========================================
	// source selection
	// ========================================

	always_comb begin
		if (mouse_mode) begin
			a_x    = mouse_x;
			a_y    = mouse_y;
			a_fire = mouse_fire;
		end else begin
			a_x    = pad1_x;
			a_y    = pad1_y;
			a_fire = pad1_buttons[PAD_FIRE_BIT];
		end
	end

	assign b_fire = pad2_buttons[PAD_FIRE_BIT];

	// swap exchanges whole ports, axes and fire together
	always_comb begin
		if (swap_ports) begin
			sel1_x    = pad2_x;
			sel1_y    = pad2_y;
			sel1_fire = b_fire;
			sel2_x    = a_x;
			sel2_y    = a_y;
			sel2_fire = a_fire;
		end else begin
			sel1_x    = a_x;
			sel1_y    = a_y;
			sel1_fire = a_fire;
			sel2_x    = pad2_x;
			sel2_y    = pad2_y;
			sel2_fire = b_fire;
		end
	end

	// ========================================
	// output registers
	// ========================================

	// idle ports read as centred, fire released
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			port1_x      <= ADC_CENTER;
			port1_y      <= ADC_CENTER;
			port2_x      <= ADC_CENTER;
			port2_y      <= ADC_CENTER;
			port1_fire_n <= 1'b1;
			port2_fire_n <= 1'b1;
		end else begin
			port1_x      <= to_adc(sel1_x);
			port1_y      <= to_adc(sel1_y);
			port2_x      <= to_adc(sel2_x);
			port2_y      <= to_adc(sel2_y);
			// emulated port expects fire active low
			port1_fire_n <= ~sel1_fire;
			port2_fire_n <= ~sel2_fire;
		end
	end

	// unswapped port 2 follows gamepad 2 fire one cycle later
	port2_fire_unswapped: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		!swap_ports |=> (port2_fire_n == !$past(pad2_buttons[PAD_FIRE_BIT]))
	);

endmodule

// File: design/mouse_axis_tracker.sv
module mouse_axis_tracker
	import mouse_pkt_pkg::*;
	import joy_port_pkg::*;
#(
	parameter int STEP_LIMIT = MOUSE_STEP_LIMIT_DEF
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  mouse_pkt_t mouse_pkt,
	input  pad_word_t  pad1_buttons,
	input  logic       mouse_disable,
	input  logic       soft_reset,
	output logic       mouse_mode,
	output axis_t      mouse_x,
	output axis_t      mouse_y,
	output logic       mouse_fire
);

	// clamp bounds in delta width
	localparam mouse_delta_t STEP_POS = mouse_delta_t'(STEP_LIMIT);
	localparam mouse_delta_t STEP_NEG = mouse_delta_t'(-STEP_LIMIT);

	// strobe level at the previous edge
	logic stb_prev;
	// new packet this cycle
	logic pkt_new;
	// any source that hands port a back to gamepad 1
	logic clear_req;

	mouse_delta_t dx_raw;
	mouse_delta_t dy_raw;
	mouse_delta_t dx_step;
	mouse_delta_t dy_step;
	mouse_sum_t   x_sum;
	mouse_sum_t   y_sum;

	// limit one packet to +/- STEP_LIMIT
	function automatic mouse_delta_t clamp_step(mouse_delta_t d);
		if (d > STEP_POS) begin
			return STEP_POS;
		end else if (d < STEP_NEG) begin
			return STEP_NEG;
		end
		return d;
	endfunction

	// pin to the signed 8-bit range
	function automatic axis_t sat_axis(mouse_sum_t s);
		if (s > mouse_sum_t'(AXIS_MAX)) begin
			return AXIS_MAX;
		end else if (s < mouse_sum_t'(AXIS_MIN)) begin
			return AXIS_MIN;
		end
		return axis_t'(s);
	endfunction

	// ========================================
	// packet decode
	// ========================================

	// packet counts on any strobe change
	assign pkt_new = stb_prev != mouse_pkt[MOUSE_STB_BIT];

	// pad activity wins over the mouse
	assign clear_req = (pad1_buttons != '0) || soft_reset || mouse_disable;

	// sign repeated twice, then the 7 low bits
	assign dx_raw = {mouse_pkt[MOUSE_XSIGN_BIT], mouse_pkt[MOUSE_XSIGN_BIT],
		mouse_pkt[MOUSE_DX_LSB +: MOUSE_DELTA_W]};
	assign dy_raw = {mouse_pkt[MOUSE_YSIGN_BIT], mouse_pkt[MOUSE_YSIGN_BIT],
		mouse_pkt[MOUSE_DY_LSB +: MOUSE_DELTA_W]};

	assign dx_step = clamp_step(dx_raw);
	assign dy_step = clamp_step(dy_raw);

	// y axis of the port runs opposite to mouse dy
	assign x_sum = mouse_sum_t'(mouse_x) + mouse_sum_t'(dx_step);
	assign y_sum = mouse_sum_t'(mouse_y) - mouse_sum_t'(dy_step);

	// ========================================
	// position state
	// ========================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			stb_prev   <= 1'b0;
			mouse_mode <= 1'b0;
			mouse_x    <= '0;
			mouse_y    <= '0;
			mouse_fire <= 1'b0;
		end else begin
			stb_prev <= mouse_pkt[MOUSE_STB_BIT];
			// clear beats a packet landing in the same cycle
			if (clear_req) begin
				mouse_mode <= 1'b0;
				mouse_x    <= '0;
				mouse_y    <= '0;
				mouse_fire <= 1'b0;
			end else if (pkt_new) begin
				mouse_mode <= 1'b1;
				mouse_x    <= sat_axis(x_sum);
				mouse_y    <= sat_axis(y_sum);
				// either button fires
				mouse_fire <= mouse_pkt[MOUSE_BTN_LEFT] | mouse_pkt[MOUSE_BTN_RIGHT];
			end
		end
	end

	// ========================================
	// checks
	// ========================================

	// clamp bound has to fit a 7-bit magnitude
	step_limit_range: assert property (
		@(posedge clk_sys) (STEP_LIMIT >= 1) && (STEP_LIMIT <= 127)
	);

	// mapper must see the gamepad source one cycle after a clear
	clear_drops_mode: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		clear_req |=> !mouse_mode
	);

endmodule

// File: design/mouse_pkt_pkg.sv
package mouse_pkt_pkg;

	// ========================================
	// host mouse packet
	// ========================================

	// 25-bit packet as delivered by the host bridge
	// [24]    strobe, toggles once per new packet
	// [23:17] low bits of y delta
	// [15:9]  low bits of x delta
	// [5]     y sign
	// [4]     x sign
	// [1:0]   right / left buttons
	typedef logic [24:0] mouse_pkt_t;

	// toggle marks a fresh packet
	localparam int MOUSE_STB_BIT = 24;

	// button positions
	localparam int MOUSE_BTN_LEFT  = 0;
	localparam int MOUSE_BTN_RIGHT = 1;

	// sign bits for the two deltas
	localparam int MOUSE_XSIGN_BIT = 4;
	localparam int MOUSE_YSIGN_BIT = 5;

	// start of the 7 low delta bits
	localparam int MOUSE_DX_LSB  = 9;
	localparam int MOUSE_DY_LSB  = 17;
	localparam int MOUSE_DELTA_W = 7;

	// ========================================
	// motion arithmetic
	// ========================================

	// sign bit doubled in front of 7 delta bits
	typedef logic signed [8:0] mouse_delta_t;

	// position plus clamped delta, wide enough to saturate afterwards
	typedef logic signed [9:0] mouse_sum_t;

	// per-packet clamp
	localparam int MOUSE_STEP_LIMIT_DEF = 10;

endpackage

// File: sim.f
+incdir+include
design/mouse_pkt_pkg.sv
design/joy_port_pkg.sv
design/mouse_axis_tracker.sv
design/joystick_port_mapper.sv
design/beeb_joy_front.sv
sim/tb_beeb_joy_front.sv

// File: include/tb_joy_model.svh
`ifndef TB_JOY_MODEL_SVH
`define TB_JOY_MODEL_SVH

// ========================================
// reference state
// ========================================

// mirror of the tracker registers
bit m_mode;
int m_x;
int m_y;
bit m_fire;
bit m_stb;

// expected port outputs
int exp_p1x;
int exp_p1y;
int exp_p2x;
int exp_p2y;
int exp_p1f;
int exp_p2f;

// back to gamepad 1, centred
function automatic void model_clear();
	m_mode = 1'b0;
	m_x    = 0;
	m_y    = 0;
	m_fire = 1'b0;
endfunction

// keep a position inside -128 .. 127
function automatic int pin_axis(int v);
	if (v > 127) begin
		return 127;
	end
	if (v < -128) begin
		return -128;
	end
	return v;
endfunction

// per-packet step bound
function automatic int limit_delta(int d);
	if (d > STEP_LIMIT) begin
		return STEP_LIMIT;
	end
	if (d < -STEP_LIMIT) begin
		return -STEP_LIMIT;
	end
	return d;
endfunction

// sign set means 7 low bits minus 128
function automatic int delta_of(bit sign, logic [6:0] low);
	int d;
	d = int'(low);
	if (sign) begin
		d = d - 128;
	end
	return d;
endfunction

// one stimulus step as seen by the tracker
function automatic void model_step(mouse_pkt_t pkt, bit clear);
	bit toggled;
	int dx;
	int dy;
	toggled = pkt[MOUSE_STB_BIT] != m_stb;
	m_stb   = pkt[MOUSE_STB_BIT];
	dx = delta_of(pkt[MOUSE_XSIGN_BIT], pkt[MOUSE_DX_LSB +: 7]);
	dy = delta_of(pkt[MOUSE_YSIGN_BIT], pkt[MOUSE_DY_LSB +: 7]);
	// clear wins over a toggle in the same step
	if (clear) begin
		model_clear();
	end else if (toggled) begin
		m_mode = 1'b1;
		m_x    = pin_axis(m_x + limit_delta(dx));
		m_y    = pin_axis(m_y - limit_delta(dy));
		m_fire = pkt[MOUSE_BTN_LEFT] | pkt[MOUSE_BTN_RIGHT];
	end
endfunction

// 127 - v mod 256, then its top nibble appended
function automatic int adc_of(int v);
	int b;
	b = (127 - v) & 255;
	return (b << 4) | (b >> 4);
endfunction

// expected six outputs from model state and pad inputs
function automatic void predict_ports(int p1x, int p1y, int p2x, int p2y,
	bit p1fire, bit p2fire, bit swap);
	int ax;
	int ay;
	bit af;
	ax = m_mode ? m_x : p1x;
	ay = m_mode ? m_y : p1y;
	af = m_mode ? m_fire : p1fire;
	exp_p1x = swap ? adc_of(p2x) : adc_of(ax);
	exp_p1y = swap ? adc_of(p2y) : adc_of(ay);
	exp_p2x = swap ? adc_of(ax) : adc_of(p2x);
	exp_p2y = swap ? adc_of(ay) : adc_of(p2y);
	// fire outputs active low
	exp_p1f = swap ? int'(!p2fire) : int'(!af);
	exp_p2f = swap ? int'(!af) : int'(!p2fire);
endfunction

`endif

// File: sim/tb_beeb_joy_front.sv
module tb_beeb_joy_front
	import mouse_pkt_pkg::*;
	import joy_port_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int STEP_LIMIT = MOUSE_STEP_LIMIT_DEF;
	localparam int CLK_HALF   = 5;
	// extra edges allowed before a wait gives up
	localparam int WAIT_SLACK = 4;
	// full-scale packets needed to cross the whole axis range
	localparam int SAT_RUN    = 256 / STEP_LIMIT + 2;

	logic       clk_sys = 1'b0;
	logic       arst_n;
	mouse_pkt_t mouse_pkt;
	pad_word_t  pad1_buttons;
	pad_word_t  pad2_buttons;
	axis_t      pad1_x;
	axis_t      pad1_y;
	axis_t      pad2_x;
	axis_t      pad2_y;
	logic       mouse_disable;
	logic       swap_ports;
	logic       soft_reset;
	adc_word_t  port1_x;
	adc_word_t  port1_y;
	adc_word_t  port2_x;
	adc_word_t  port2_y;
	logic       port1_fire_n;
	logic       port2_fire_n;

	string test_name;
	int    fail_count;
	event  check_ev;

	`include "tb_joy_model.svh"

	beeb_joy_front #(
		.MOUSE_STEP_LIMIT (STEP_LIMIT)
	) u_beeb_joy_front (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.mouse_pkt     (mouse_pkt),
		.pad1_buttons  (pad1_buttons),
		.pad2_buttons  (pad2_buttons),
		.pad1_x        (pad1_x),
		.pad1_y        (pad1_y),
		.pad2_x        (pad2_x),
		.pad2_y        (pad2_y),
		.mouse_disable (mouse_disable),
		.swap_ports    (swap_ports),
		.soft_reset    (soft_reset),
		.port1_x       (port1_x),
		.port1_y       (port1_y),
		.port2_x       (port2_x),
		.port2_y       (port2_y),
		.port1_fire_n  (port1_fire_n),
		.port2_fire_n  (port2_fire_n)
	);

	// 10 ns clock
	always #CLK_HALF clk_sys = ~clk_sys;

	// ========================================
	// helpers
	// ========================================

	task automatic abort_run(input string reason);
		fail_count++;
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string what, input int exp, input int act);
		assert (exp == act) else begin
			abort_run($sformatf("Mismatch in %s: %s expected 0x%0h actual 0x%0h",
				test_name, what, exp, act));
		end
	endtask

	// falling edges, bounded in time
	task automatic wait_falling(input int n);
		int      seen;
		realtime deadline;
		seen     = 0;
		deadline = $realtime + (n + WAIT_SLACK) * 2 * CLK_HALF;
		while (seen < n) begin
			@(negedge clk_sys);
			seen++;
			if ($realtime > deadline) begin
				abort_run($sformatf("wait for %0d falling edges timed out in %s",
					n, test_name));
			end
		end
	endtask

	// compare now, resume at the next falling edge
	task automatic check_now(input string name);
		test_name = name;
		-> check_ev;
		wait_falling(1);
	endtask

	// inputs already driven at this falling edge
	task automatic run_step(input string name);
		test_name = name;
		model_step(mouse_pkt, (pad1_buttons != '0) || soft_reset || mouse_disable);
		// tracker edge then mapper edge
		wait_falling(2);
		check_now(name);
	endtask

	function automatic mouse_pkt_t make_pkt(bit stb, int dx, int dy, bit [1:0] btn);
		mouse_pkt_t p;
		p = '0;
		p[MOUSE_STB_BIT]      = stb;
		p[MOUSE_BTN_LEFT]     = btn[0];
		p[MOUSE_BTN_RIGHT]    = btn[1];
		p[MOUSE_XSIGN_BIT]    = dx < 0;
		p[MOUSE_YSIGN_BIT]    = dy < 0;
		p[MOUSE_DX_LSB +: 7]  = 7'(dx);
		p[MOUSE_DY_LSB +: 7]  = 7'(dy);
		return p;
	endfunction

	// flip the strobe so the tracker sees a new packet
	task automatic next_pkt(input int dx, input int dy, input bit [1:0] btn);
		mouse_pkt = make_pkt(!mouse_pkt[MOUSE_STB_BIT], dx, dy, btn);
	endtask

	task automatic send_packet(input string name, input int dx, input int dy,
		input bit [1:0] btn);
		next_pkt(dx, dy, btn);
		run_step(name);
	endtask

	task automatic send_random_packets(input string name, input int count);
		for (int i = 0; i < count; i++) begin
			send_packet(name, int'($urandom_range(120, 0)) - 60,
				int'($urandom_range(120, 0)) - 60, 2'($urandom));
		end
	endtask

	// first steps hit the axis corners
	function automatic axis_t pick_axis(int i);
		case (i)
			0: return axis_t'(-128);
			1: return axis_t'(0);
			2: return axis_t'(127);
			default: return axis_t'($urandom);
		endcase
	endfunction

	task automatic drive_pads(input int i, input bit fire1);
		pad1_x       = pick_axis(i);
		pad1_y       = pick_axis(i);
		pad2_x       = pick_axis(i);
		pad2_y       = pick_axis(i);
		pad2_buttons = pad_word_t'($urandom);
		pad1_buttons = '0;
		pad1_buttons[PAD_FIRE_BIT] = fire1 & 1'($urandom);
	endtask

	// ========================================
	// comparison process
	// ========================================

	always @(check_ev) begin
		predict_ports(int'(pad1_x), int'(pad1_y), int'(pad2_x), int'(pad2_y),
			pad1_buttons[PAD_FIRE_BIT], pad2_buttons[PAD_FIRE_BIT], swap_ports);
		check_value("port1_x", exp_p1x, int'(port1_x));
		check_value("port1_y", exp_p1y, int'(port1_y));
		check_value("port2_x", exp_p2x, int'(port2_x));
		check_value("port2_y", exp_p2y, int'(port2_y));
		check_value("port1_fire_n", exp_p1f, int'(port1_fire_n));
		check_value("port2_fire_n", exp_p2f, int'(port2_fire_n));
	end

	// ========================================
	// test sequence
	// ========================================

	initial begin
		void'($urandom(32'hb3ba68f9));
		fail_count    = 0;
		test_name     = "reset_state";
		arst_n        = 1'b0;
		mouse_pkt     = '0;
		pad1_buttons  = '0;
		pad2_buttons  = '0;
		pad1_x        = '0;
		pad1_y        = '0;
		pad2_x        = '0;
		pad2_y        = '0;
		mouse_disable = 1'b0;
		swap_ports    = 1'b0;
		soft_reset    = 1'b0;
		m_stb         = 1'b0;
		model_clear();

		// reset held over 4 rising edges
		wait_falling(4);
		arst_n = 1'b1;
		check_now("reset_state");
		run_step("reset_idle");

		for (int i = 0; i < 24; i++) begin
			drive_pads(i, 1'b1);
			run_step("pad_passthru");
		end

		// mouse takes port 1 once pad 1 is idle
		drive_pads(3, 1'b0);
		send_random_packets("mouse_track", 30);

		for (int i = 0; i < SAT_RUN; i++) begin
			send_packet("sat_pos", 127, -128, 2'b00);
		end
		check_value("port1_x pinned", adc_of(127), int'(port1_x));
		check_value("port1_y pinned", adc_of(127), int'(port1_y));
		for (int i = 0; i < SAT_RUN; i++) begin
			send_packet("sat_neg", -128, 127, 2'b10);
		end
		check_value("port1_x pinned", adc_of(-128), int'(port1_x));
		check_value("port1_y pinned", adc_of(-128), int'(port1_y));

		// pad button with a packet in the same cycle
		send_random_packets("clear_setup", 3);
		pad1_buttons = 16'h0080;
		next_pkt(40, -40, 2'b01);
		run_step("clear_pad_button");
		pad1_buttons = '0;
		run_step("clear_pad_release");

		send_random_packets("clear_setup", 3);
		soft_reset = 1'b1;
		next_pkt(-30, 30, 2'b11);
		run_step("clear_soft_reset");
		soft_reset = 1'b0;
		run_step("clear_soft_release");

		send_random_packets("clear_setup", 3);
		mouse_disable = 1'b1;
		run_step("clear_mouse_disable");
		send_random_packets("clear_disabled_pkt", 2);
		mouse_disable = 1'b0;
		run_step("clear_disable_release");

		// swap in gamepad mode, then in mouse mode
		swap_ports = 1'b1;
		for (int i = 0; i < 8; i++) begin
			drive_pads(i + 3, 1'b1);
			run_step("swap_pad");
		end
		drive_pads(3, 1'b0);
		send_random_packets("swap_mouse", 8);
		swap_ports = 1'b0;
		run_step("swap_release");

		if (fail_count == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			abort_run("checks failed before the end of the run");
		end
	end

endmodule
